// File: hw/wordGamePkg.sv
// shared letter type, controller states and display constants for the word-guessing game
package wordGamePkg;

    // one ASCII character of the secret word or of a guess
    typedef logic [7:0] letter_t;

    // controller states
    // ENTRY waits for the host word and the start strobe
    // SCAN walks the word one position per cycle
    // JUDGE scores the guess and picks the next state
    typedef enum logic [2:0] {
        ENTRY     = 3'd0,
        WAITGUESS = 3'd1,
        SCAN      = 3'd2,
        JUDGE     = 3'd3,
        WON       = 3'd4,
        LOST      = 3'd5
    } gameState_t;

    // width of the mistake counter and of mistakes left
    localparam int COUNT_W = 4;

    // underscore for a position not yet revealed
    localparam letter_t HIDDEN_CHAR = 8'h5F;

endpackage

// File: hw/gameStatusIf.sv
// per-guess result bundle from the game controller to the display block
`timescale 1ns/1ps

interface gameStatusIf #(
    parameter int WORD_LEN = 5
);
    import wordGamePkg::*;

    // all fields are valid only while resultValid is high
    logic                resultValid;
    logic [WORD_LEN-1:0] hitMask;
    logic                lastHit;
    logic [COUNT_W-1:0]  mistakes;
    logic                won;
    logic                lost;

    modport ctrl (
        output resultValid,
        output hitMask,
        output lastHit,
        output mistakes,
        output won,
        output lost
    );

    modport view (
        input resultValid,
        input hitMask,
        input lastHit,
        input mistakes,
        input won,
        input lost
    );

endinterface

// File: hw/wordLoader.sv
// secret word shift register; the host strobes letters in until the word is full
`timescale 1ns/1ps

module wordLoader #(
    parameter int WORD_LEN = 5
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  wordGamePkg::letter_t                 letterIn,
    input  logic                                 letterValid,
    input  logic                                 clear,
    output wordGamePkg::letter_t [WORD_LEN-1:0] word,
    output logic                                 wordReady
);
    localparam int CNT_W = $clog2(WORD_LEN + 1);

    logic [CNT_W-1:0] count;
    logic             shiftEn;

    // full word means further letters are dropped
    assign wordReady = (count == CNT_W'(WORD_LEN));
    assign shiftEn   = letterValid && !wordReady && !clear;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (shiftEn) begin
            count <= count + 1'b1;
        end
    end

    // letters enter at the top and move down
    // so the first letter ends up in position 0
    always_ff @(posedge clk) begin
        if (clear) begin
            word <= '0;
        end else if (shiftEn) begin
            for (int i = 0; i < WORD_LEN - 1; i++) begin
                word[i] <= word[i+1];
            end
            word[WORD_LEN-1] <= letterIn;
        end
    end

endmodule

// File: hw/gameLogic.sv
// game controller FSM; scans the secret word one position per cycle and scores each guess
`timescale 1ns/1ps

module gameLogic #(
    parameter int WORD_LEN     = 5,
    parameter int MAX_MISTAKES = 6
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  wordGamePkg::letter_t [WORD_LEN-1:0] word,
    input  logic                                 wordReady,
    input  logic                                 startGame,
    input  wordGamePkg::letter_t                 guessLetter,
    input  logic                                 guessValid,
    input  logic                                 newGame,
    output logic                                 guessReady,
    output logic                                 clearWord,
    gameStatusIf.ctrl                            status
);
    import wordGamePkg::*;

    localparam int IDX_W = (WORD_LEN > 1) ? $clog2(WORD_LEN) : 1;

    gameState_t          state;
    gameState_t          nextState;
    logic [IDX_W-1:0]    posIdx;
    letter_t             guessHeld;
    logic [WORD_LEN-1:0] hitMask;
    logic                anyHit;
    logic [COUNT_W-1:0]  mistakeCount;
    logic [COUNT_W-1:0]  mistakeNext;
    logic                accept;
    logic                lastPos;
    logic                fullMask;
    logic                outOfTries;
    logic                gameOver;

    assign guessReady = (state == WAITGUESS);
    assign accept     = guessReady && guessValid;
    assign lastPos    = (posIdx == IDX_W'(WORD_LEN - 1));
    assign fullMask   = &hitMask;
    assign gameOver   = (state == WON) || (state == LOST);
    assign clearWord  = gameOver && newGame;

    // a miss only counts once the whole word has been scanned
    assign mistakeNext = (state == JUDGE && !anyHit) ? mistakeCount + 1'b1 : mistakeCount;
    assign outOfTries  = (mistakeNext >= COUNT_W'(MAX_MISTAKES));

    always_comb begin
        nextState = state;
        case (state)
            ENTRY: begin
                if (startGame && wordReady) begin
                    nextState = WAITGUESS;
                end
            end
            WAITGUESS: begin
                if (accept) begin
                    nextState = SCAN;
                end
            end
            SCAN: begin
                if (lastPos) begin
                    nextState = JUDGE;
                end
            end
            JUDGE: begin
                // win wins over loss on the same guess
                if (fullMask) begin
                    nextState = WON;
                end else if (outOfTries) begin
                    nextState = LOST;
                end else begin
                    nextState = WAITGUESS;
                end
            end
            WON, LOST: begin
                if (newGame) begin
                    nextState = ENTRY;
                end
            end
            default: nextState = ENTRY;
        endcase
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state        <= ENTRY;
            posIdx       <= '0;
            hitMask      <= '0;
            anyHit       <= 1'b0;
            mistakeCount <= '0;
        end else begin
            state <= nextState;
            case (state)
                WAITGUESS: begin
                    if (accept) begin
                        posIdx <= '0;
                        anyHit <= 1'b0;
                    end
                end
                SCAN: begin
                    if (word[posIdx] == guessHeld) begin
                        hitMask[posIdx] <= 1'b1;
                        anyHit          <= 1'b1;
                    end
                    posIdx <= lastPos ? '0 : posIdx + 1'b1;
                end
                JUDGE: mistakeCount <= mistakeNext;
                WON, LOST: begin
                    if (newGame) begin
                        hitMask      <= '0;
                        mistakeCount <= '0;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            guessHeld <= guessLetter;
        end
    end

    // result goes out during the JUDGE cycle
    assign status.resultValid = (state == JUDGE);
    assign status.hitMask     = hitMask;
    assign status.lastHit     = anyHit;
    assign status.mistakes    = mistakeNext;
    assign status.won         = (state == JUDGE) ? fullMask : (state == WON);
    assign status.lost        = (state == JUDGE) ? (!fullMask && outOfTries) : (state == LOST);

endmodule

// File: hw/statusDisplay.sv
// display view of the game; holds the revealed word, mistakes left and the win/lose lamps
`timescale 1ns/1ps

module statusDisplay #(
    parameter int WORD_LEN     = 5,
    parameter int MAX_MISTAKES = 6
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  wordGamePkg::letter_t [WORD_LEN-1:0] word,
    gameStatusIf.view                            status,
    input  logic                                 newGame,
    output wordGamePkg::letter_t [WORD_LEN-1:0] revealedWord,
    output logic [wordGamePkg::COUNT_W-1:0]      mistakesLeft,
    output logic                                 winLed,
    output logic                                 loseLed
);
    import wordGamePkg::*;

    localparam letter_t [WORD_LEN-1:0] HIDDEN_WORD = {WORD_LEN{HIDDEN_CHAR}};

    letter_t [WORD_LEN-1:0] shownWord;
    logic                   lampLit;

    // secret letter where the mask is set, underscore elsewhere
    always_comb begin
        for (int i = 0; i < WORD_LEN; i++) begin
            shownWord[i] = status.hitMask[i] ? word[i] : HIDDEN_CHAR;
        end
    end

    assign lampLit = winLed || loseLed;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            revealedWord <= HIDDEN_WORD;
            mistakesLeft <= COUNT_W'(MAX_MISTAKES);
            winLed       <= 1'b0;
            loseLed      <= 1'b0;
        end else if (newGame && lampLit) begin
            // back to the blank board for the next round
            revealedWord <= HIDDEN_WORD;
            mistakesLeft <= COUNT_W'(MAX_MISTAKES);
            winLed       <= 1'b0;
            loseLed      <= 1'b0;
        end else if (status.resultValid) begin
            revealedWord <= shownWord;
            mistakesLeft <= COUNT_W'(MAX_MISTAKES) - status.mistakes;
            // lamps stay lit until a new game
            if (status.won) begin
                winLed <= 1'b1;
            end
            if (status.lost) begin
                loseLed <= 1'b1;
            end
        end
    end

endmodule

// File: hw/wordGameTop.sv
// top level of the word-guessing game; joins loader, controller and display on plain ports
`timescale 1ns/1ps

module wordGameTop #(
    parameter int WORD_LEN     = 5,
    parameter int MAX_MISTAKES = 6
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  wordGamePkg::letter_t                 hostLetter,
    input  logic                                 hostLetterValid,
    input  logic                                 startGame,
    input  wordGamePkg::letter_t                 guessLetter,
    input  logic                                 guessValid,
    input  logic                                 newGame,
    output logic                                 wordReady,
    output logic                                 guessReady,
    output logic                                 resultValid,
    output logic                                 lastHit,
    output logic [WORD_LEN-1:0]                  hitMask,
    output wordGamePkg::letter_t [WORD_LEN-1:0] revealedWord,
    output logic [wordGamePkg::COUNT_W-1:0]      mistakesLeft,
    output logic                                 winLed,
    output logic                                 loseLed
);
    import wordGamePkg::*;

    letter_t [WORD_LEN-1:0] secretWord;
    logic                   clearWord;

    gameStatusIf #(.WORD_LEN(WORD_LEN)) statusBus ();

    wordLoader #(.WORD_LEN(WORD_LEN)) loader (
        .clk         (clk),
        .nRst        (nRst),
        .letterIn    (hostLetter),
        .letterValid (hostLetterValid),
        .clear       (clearWord),
        .word        (secretWord),
        .wordReady   (wordReady)
    );

    gameLogic #(.WORD_LEN(WORD_LEN), .MAX_MISTAKES(MAX_MISTAKES)) ctrl (
        .clk         (clk),
        .nRst        (nRst),
        .word        (secretWord),
        .wordReady   (wordReady),
        .startGame   (startGame),
        .guessLetter (guessLetter),
        .guessValid  (guessValid),
        .newGame     (newGame),
        .guessReady  (guessReady),
        .clearWord   (clearWord),
        .status      (statusBus.ctrl)
    );

    statusDisplay #(.WORD_LEN(WORD_LEN), .MAX_MISTAKES(MAX_MISTAKES)) display (
        .clk          (clk),
        .nRst         (nRst),
        .word         (secretWord),
        .status       (statusBus.view),
        .newGame      (newGame),
        .revealedWord (revealedWord),
        .mistakesLeft (mistakesLeft),
        .winLed       (winLed),
        .loseLed      (loseLed)
    );

    // raw per-guess result straight from the controller
    assign resultValid = statusBus.resultValid;
    assign lastHit     = statusBus.lastHit;
    assign hitMask     = statusBus.hitMask;

endmodule

// File: verif/gameLogic_props.sv
// concurrent checks on the game controller FSM, attached to every gameLogic instance by bind
`timescale 1ns/1ps

module gameLogicProps #(
    parameter int MAX_MISTAKES = 6
) (
    input logic                              clk,
    input logic                              nRst,
    input logic                              accept,
    input logic                              guessReady,
    input logic                              resultValid,
    input logic [wordGamePkg::COUNT_W-1:0]  mistakeCount,
    input logic                              won,
    input logic                              lost
);
    logic scanBusy;

    // high from the accepting edge until the result strobe has been sampled
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            scanBusy <= 1'b0;
        end else if (accept) begin
            scanBusy <= 1'b1;
        end else if (resultValid) begin
            scanBusy <= 1'b0;
        end
    end

    resultOneCycle: assert property (@(posedge clk) disable iff (!nRst)
        resultValid |=> !resultValid)
        else $error("resultValid stayed high for more than one cycle");

    busyNotReady: assert property (@(posedge clk) disable iff (!nRst)
        scanBusy |-> !guessReady)
        else $error("guessReady high while a guess is still being scanned");

    mistakesBounded: assert property (@(posedge clk) disable iff (!nRst)
        mistakeCount <= MAX_MISTAKES)
        else $error("mistake count above the limit");

    wonLostExclusive: assert property (@(posedge clk) disable iff (!nRst)
        !(won && lost))
        else $error("won and lost raised together");

endmodule

bind gameLogic gameLogicProps #(.MAX_MISTAKES(MAX_MISTAKES)) props (
    .clk          (clk),
    .nRst         (nRst),
    .accept       (accept),
    .guessReady   (guessReady),
    .resultValid  (status.resultValid),
    .mistakeCount (mistakeCount),
    .won          (status.won),
    .lost         (status.lost)
);

// File: verif/tb_wordGame.sv
// directed testbench for the word game top level; run it through sim.f with the build script
`timescale 1ns/1ps

module tb_wordGame;
    import wordGamePkg::*;

    localparam int WORD_LEN       = 5;
    localparam int MAX_MISTAKES   = 6;
    localparam int RESULT_DELAY   = WORD_LEN + 1;
    localparam int TOTAL_GUESSES  = 15;
    localparam int TIMEOUT_CYCLES = TOTAL_GUESSES * 10 + 200;

    logic                   clk;
    logic                   nRst;
    letter_t                hostLetter;
    logic                   hostLetterValid;
    logic                   startGame;
    letter_t                guessLetter;
    logic                   guessValid;
    logic                   newGame;
    logic                   wordReady;
    logic                   guessReady;
    logic                   resultValid;
    logic                   lastHit;
    logic [WORD_LEN-1:0]    hitMask;
    letter_t [WORD_LEN-1:0] revealedWord;
    logic [COUNT_W-1:0]     mistakesLeft;
    logic                   winLed;
    logic                   loseLed;

    // reference model of the round in progress
    letter_t             secret [WORD_LEN];
    logic [WORD_LEN-1:0] modelMask;
    int                  modelMistakes;
    bit                  modelWon;
    bit                  modelLost;

    int     errorCount = 0;
    int     guessCount = 0;
    int     resultCount = 0;
    int     cycleCount = 0;
    integer seed;
    bit     runClosed = 1'b0;

    wordGameTop #(.WORD_LEN(WORD_LEN), .MAX_MISTAKES(MAX_MISTAKES)) dut (
        .clk             (clk),
        .nRst            (nRst),
        .hostLetter      (hostLetter),
        .hostLetterValid (hostLetterValid),
        .startGame       (startGame),
        .guessLetter     (guessLetter),
        .guessValid      (guessValid),
        .newGame         (newGame),
        .wordReady       (wordReady),
        .guessReady      (guessReady),
        .resultValid     (resultValid),
        .lastHit         (lastHit),
        .hitMask         (hitMask),
        .revealedWord    (revealedWord),
        .mistakesLeft    (mistakesLeft),
        .winLed          (winLed),
        .loseLed         (loseLed)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            runClosed = 1'b1;
            $display("Simulation FAILED");
            $finish;
        end
    end

    // every result strobe, wanted or not
    always @(negedge clk) begin
        if (resultValid) begin
            resultCount++;
        end
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // board as it should look for the current mask
    function automatic logic [8*WORD_LEN-1:0] expectedView();
        logic [8*WORD_LEN-1:0] view;
        int i;
        for (i = 0; i < WORD_LEN; i++) begin
            view[8*i +: 8] = modelMask[i] ? secret[i] : 8'h5F;
        end
        return view;
    endfunction

    function automatic letter_t drawAbsentLetter();
        letter_t pick;
        bit present;
        int i;
        present = 1'b1;
        while (present) begin
            pick = letter_t'(8'h41 + ($unsigned($random(seed)) % 26));
            present = 1'b0;
            for (i = 0; i < WORD_LEN; i++) begin
                present = present || (secret[i] == pick);
            end
        end
        return pick;
    endfunction

    task automatic checkResetView();
        check("wordReady", 0, wordReady);
        check("guessReady", 0, guessReady);
        check("revealedWord", {WORD_LEN{8'h5F}}, revealedWord);
        check("mistakesLeft", MAX_MISTAKES, mistakesLeft);
        check("winLed", 0, winLed);
        check("loseLed", 0, loseLed);
    endtask

    task automatic loadWord(input string w);
        int i;
        for (i = 0; i < WORD_LEN; i++) begin
            secret[i] = w[i];
        end
        for (i = 0; i < WORD_LEN; i++) begin
            @(negedge clk);
            check("wordReady", 0, wordReady);
            hostLetter = secret[i];
            hostLetterValid = 1'b1;
        end
        @(negedge clk);
        hostLetterValid = 1'b0;
        check("wordReady", 1, wordReady);
    endtask

    task automatic startRound();
        modelMask = '0;
        modelMistakes = 0;
        modelWon = 1'b0;
        modelLost = 1'b0;
        @(negedge clk);
        check("guessReady", 0, guessReady);
        startGame = 1'b1;
        @(negedge clk);
        startGame = 1'b0;
        check("guessReady", 1, guessReady);
    endtask

    task automatic waitGuessReady();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!guessReady && waited < 4 * WORD_LEN) begin
            @(negedge clk);
            waited++;
        end
        if (!guessReady) begin
            $display("Error at %0t ns: guessReady never rose for the next guess", $time);
            errorCount++;
        end
    endtask

    // one guess, optionally with a stray strobe while the word is scanned
    task automatic guess(input letter_t letter, input bit injectStray);
        logic [WORD_LEN-1:0] hitsNow;
        int cycles;
        int i;
        hitsNow = '0;
        for (i = 0; i < WORD_LEN; i++) begin
            hitsNow[i] = (secret[i] == letter);
        end
        modelMask = modelMask | hitsNow;
        if (hitsNow == '0) begin
            modelMistakes++;
        end
        modelWon = &modelMask;
        modelLost = !modelWon && (modelMistakes >= MAX_MISTAKES);
        waitGuessReady();
        guessLetter = letter;
        guessValid = 1'b1;
        guessCount++;
        @(negedge clk);
        guessValid = 1'b0;
        cycles = 1;
        check("guessReady", 0, guessReady);
        while (!resultValid && cycles < 4 * WORD_LEN) begin
            guessValid = injectStray && (cycles == 2);
            guessLetter = guessValid ? secret[0] : letter;
            @(negedge clk);
            cycles++;
        end
        guessValid = 1'b0;
        if (!resultValid) begin
            $display("Error at %0t ns: no result for guess %s", $time, letter);
            errorCount++;
        end else begin
            check("resultDelay", RESULT_DELAY, cycles);
            check("lastHit", hitsNow != '0, lastHit);
            check("hitMask", modelMask, hitMask);
        end
        // display registers the result one cycle later
        @(negedge clk);
        check("resultValid", 0, resultValid);
        check("revealedWord", expectedView(), revealedWord);
        check("mistakesLeft", MAX_MISTAKES - modelMistakes, mistakesLeft);
        check("winLed", modelWon, winLed);
        check("loseLed", modelLost, loseLed);
        check("guessReady", !(modelWon || modelLost), guessReady);
    endtask

    task automatic expectNoResult(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (resultValid) begin
                $display("Error at %0t ns: result strobe with no guess pending", $time);
                errorCount++;
            end
        end
    endtask

    task automatic restartGame();
        @(negedge clk);
        newGame = 1'b1;
        @(negedge clk);
        newGame = 1'b0;
        checkResetView();
    endtask

    task automatic testResetAndLoad();
        checkResetView();
        loadWord("LEVEL");
        // a sixth letter must be dropped
        @(negedge clk);
        hostLetter = "Z";
        hostLetterValid = 1'b1;
        @(negedge clk);
        hostLetterValid = 1'b0;
        check("wordReady", 1, wordReady);
        startRound();
    endtask

    task automatic testMultiHit();
        guess("E", 1'b0);
    endtask

    // Z only reaches the word if the sixth letter got in
    task automatic testMissAndStray();
        guess("Z", 1'b1);
        expectNoResult(2 * WORD_LEN);
    endtask

    task automatic testWin();
        guess("L", 1'b0);
        guess("V", 1'b0);
        check("winLed", 1, winLed);
        restartGame();
    endtask

    task automatic testLoseAndReplay();
        int n;
        loadWord("CRANE");
        startRound();
        for (n = 0; n < MAX_MISTAKES; n++) begin
            guess(drawAbsentLetter(), 1'b0);
        end
        check("loseLed", 1, loseLed);
        check("mistakesLeft", 0, mistakesLeft);
        restartGame();
        loadWord("QUICK");
        startRound();
        for (n = 0; n < WORD_LEN; n++) begin
            guess(secret[n], 1'b0);
        end
        check("winLed", 1, winLed);
    endtask

    initial begin
        seed = 32'hbaadf52a;
        nRst = 1'b0;
        hostLetter = '0;
        hostLetterValid = 1'b0;
        startGame = 1'b0;
        guessLetter = '0;
        guessValid = 1'b0;
        newGame = 1'b0;
        repeat (5) @(negedge clk);
        nRst = 1'b1;

        testResetAndLoad();
        testMultiHit();
        testMissAndStray();
        testWin();
        testLoseAndReplay();

        @(negedge clk);
        if (resultCount != guessCount) begin
            $display("Error: %0d result strobes seen for %0d guesses", resultCount, guessCount);
            errorCount++;
        end
        $display("Summary: %0d errors over %0d guesses", errorCount, guessCount);
        runClosed = 1'b1;
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // run stopped early, e.g. by a failed assertion
    final begin
        if (!runClosed) begin
            $display("Run ended before the testbench reached its summary");
            $display("Simulation FAILED");
        end
    end

endmodule

// File: sim.f
hw/wordGamePkg.sv
hw/gameStatusIf.sv
hw/wordLoader.sv
hw/gameLogic.sv
hw/statusDisplay.sv
hw/wordGameTop.sv
verif/gameLogic_props.sv
verif/tb_wordGame.sv

// File: run.sh
#!/usr/bin/env bash
# build the word game testbench with Verilator, run it and scan the log for failure
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_wordGame -Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation FAILED" "$logFile"; then
    echo "testbench reported failure, see $logFile"
    exit 1
fi

echo "testbench reported no failure"
exit 0
